/* design/hf_pkg.sv */
`default_nettype none

package hf_pkg;

    localparam int WORD_W     = 16;
    localparam int REG_N      = 16;
    localparam int REG_W      = 4;
    localparam int ADDR_W     = 8;
    localparam int INSTR_W    = 32;
    localparam int HF_SIZE    = 8;
    localparam int HF_PTR     = 3;
    localparam int MUL_STAGES = 3;

    typedef enum logic [2:0] {
        NOP,
        ADD,
        SUB,
        XOR,
        LI,
        MUL,
        TRAP
    } opcode_e;

    // instruction word from msb down, bit 31 is spare
    typedef struct packed {
        logic              spare;
        opcode_e           op;
        logic [REG_W-1:0]  rd;
        logic [REG_W-1:0]  rs1;
        logic [REG_W-1:0]  rs2;
        logic [WORD_W-1:0] imm;
    } instr_t;

    typedef struct packed {
        logic              valid;
        opcode_e           op;
        logic [REG_W-1:0]  rd;
        logic [WORD_W-1:0] a;
        logic [WORD_W-1:0] b;
        logic [WORD_W-1:0] imm;
        logic [HF_PTR-1:0] id;
    } issue_t;

    typedef struct packed {
        logic              valid;
        logic [REG_W-1:0]  rd;
        logic [WORD_W-1:0] old_value;
        logic [ADDR_W-1:0] pc;
    } hf_req_t;

    typedef struct packed {
        logic              valid;
        logic [HF_PTR-1:0] id;
        logic [REG_W-1:0]  rd;
        logic [WORD_W-1:0] result;
        logic              exc;
    } complete_t;

    typedef struct packed {
        logic              valid;
        logic [REG_W-1:0]  rd;
        logic [WORD_W-1:0] value;
    } rollback_t;

    typedef enum logic [1:0] {NORMAL, WAIT_IDLE, RECOVERING} hf_status_e;

    typedef enum logic [1:0] {EMPTY, EXECUTING, EXEC_OK, EXCEPTION} entry_status_e;

endpackage

`default_nettype wire

/* design/hf_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module hf_decode (
    input  wire logic                       clk_i,
    input  wire logic                       rst_i,
    input  wire logic                       instr_valid_i,
    input  wire logic [hf_pkg::INSTR_W-1:0] instr_i,
    input  wire logic [hf_pkg::ADDR_W-1:0]  pc_i,
    input  wire logic [hf_pkg::HF_PTR-1:0]  tail_id_i,
    input  wire logic                       hf_full_i,
    input  wire logic                       hf_normal_i,
    input  wire logic [hf_pkg::WORD_W-1:0]  rs1_data_i,
    input  wire logic [hf_pkg::WORD_W-1:0]  rs2_data_i,
    input  wire logic [hf_pkg::WORD_W-1:0]  rd_old_i,
    input  wire hf_pkg::complete_t          complete_alu_i,
    input  wire hf_pkg::complete_t          complete_mul_i,
    output logic [hf_pkg::REG_W-1:0]        rs1_addr_o,
    output logic [hf_pkg::REG_W-1:0]        rs2_addr_o,
    output logic [hf_pkg::REG_W-1:0]        rd_addr_o,
    output hf_pkg::issue_t                  issue_o,
    output hf_pkg::hf_req_t                 hf_req_o,
    output logic                            issue_stall_o
);
    import hf_pkg::*;

    instr_t           instr;
    logic [REG_N-1:0] pending_q;
    logic             uses_src;
    logic             hazard;
    logic             take;

    assign instr = instr_t'(instr_i);

    assign rs1_addr_o = instr.rs1;
    assign rs2_addr_o = instr.rs2;
    assign rd_addr_o  = instr.rd;

    // LI and TRAP read no source registers
    assign uses_src = instr.op inside {ADD, SUB, XOR, MUL};

    // a pending destination also keeps the saved old value exact for rollback
    always_comb begin
        hazard = 1'b0;
        if (instr_valid_i && instr.op != NOP) begin
            hazard = pending_q[instr.rd];
            if (uses_src) begin
                hazard = hazard | pending_q[instr.rs1] | pending_q[instr.rs2];
            end
        end
    end

    assign issue_stall_o = hazard || hf_full_i || !hf_normal_i;

    // a NOP is accepted and then dropped here
    assign take = instr_valid_i && !issue_stall_o && (instr.op != NOP);

    assign hf_req_o = '{valid: take, rd: instr.rd, old_value: rd_old_i, pc: pc_i};

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pending_q <= '0;
        end else begin
            for (int r = 0; r < REG_N; r++) begin
                if ((complete_alu_i.valid && complete_alu_i.rd == REG_W'(r)) ||
                    (complete_mul_i.valid && complete_mul_i.rd == REG_W'(r))) begin
                    pending_q[r] <= 1'b0;
                end
            end
            if (take) begin
                pending_q[instr.rd] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            issue_o.valid <= 1'b0;
        end else begin
            issue_o.valid <= take;
            if (take) begin
                issue_o.op  <= instr.op;
                issue_o.rd  <= instr.rd;
                issue_o.a   <= rs1_data_i;
                issue_o.b   <= rs2_data_i;
                issue_o.imm <= instr.imm;
                issue_o.id  <= tail_id_i;
            end
        end
    end

endmodule

`default_nettype wire

/* design/hf_execute.sv */
`timescale 1ns/1ps
`default_nettype none

module hf_execute (
    input  wire logic           clk_i,
    input  wire logic           rst_i,
    input  wire hf_pkg::issue_t issue_i,
    output hf_pkg::complete_t   complete_alu_o,
    output hf_pkg::complete_t   complete_mul_o,
    output logic                busy_o
);
    import hf_pkg::*;

    complete_t           mul_q [MUL_STAGES];
    logic [WORD_W-1:0]   alu_res;
    logic [2*WORD_W-1:0] product;
    logic                is_alu;
    logic                is_mul;
    logic                mul_busy;

    assign is_alu = issue_i.valid && (issue_i.op inside {ADD, SUB, XOR, LI, TRAP});
    assign is_mul = issue_i.valid && (issue_i.op == MUL);

    always_comb begin
        case (issue_i.op)
            ADD:     alu_res = issue_i.a + issue_i.b;
            SUB:     alu_res = issue_i.a - issue_i.b;
            XOR:     alu_res = issue_i.a ^ issue_i.b;
            LI:      alu_res = issue_i.imm;
            default: alu_res = '0;
        endcase
    end

    // single cycle lane, TRAP reports through it with the exception flag set
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            complete_alu_o.valid <= 1'b0;
        end else begin
            complete_alu_o.valid <= is_alu;
            if (is_alu) begin
                complete_alu_o.id     <= issue_i.id;
                complete_alu_o.rd     <= issue_i.rd;
                complete_alu_o.result <= alu_res;
                complete_alu_o.exc    <= (issue_i.op == TRAP);
            end
        end
    end

    assign product = issue_i.a * issue_i.b;

    // the product is formed in the first stage and then only travels
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int s = 0; s < MUL_STAGES; s++) begin
                mul_q[s].valid <= 1'b0;
            end
        end else begin
            mul_q[0].valid  <= is_mul;
            mul_q[0].id     <= issue_i.id;
            mul_q[0].rd     <= issue_i.rd;
            mul_q[0].result <= product[WORD_W-1:0];
            mul_q[0].exc    <= 1'b0;
            for (int s = 1; s < MUL_STAGES; s++) begin
                mul_q[s] <= mul_q[s-1];
            end
        end
    end

    assign complete_mul_o = mul_q[MUL_STAGES-1];

    always_comb begin
        mul_busy = 1'b0;
        for (int s = 0; s < MUL_STAGES; s++) begin
            mul_busy = mul_busy | mul_q[s].valid;
        end
    end

    // work sitting at the lane inputs counts too, it completes later
    assign busy_o = issue_i.valid || complete_alu_o.valid || mul_busy;

endmodule

`default_nettype wire

/* design/hf_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module hf_regfile (
    input  wire logic                     clk_i,
    input  wire logic                     rst_i,
    input  wire hf_pkg::complete_t        wr_alu_i,
    input  wire hf_pkg::complete_t        wr_mul_i,
    input  wire hf_pkg::rollback_t        rollback_i,
    input  wire logic [hf_pkg::REG_W-1:0] rs1_addr_i,
    output logic [hf_pkg::WORD_W-1:0]     rs1_data_o,
    input  wire logic [hf_pkg::REG_W-1:0] rs2_addr_i,
    output logic [hf_pkg::WORD_W-1:0]     rs2_data_o,
    input  wire logic [hf_pkg::REG_W-1:0] rd_addr_i,
    output logic [hf_pkg::WORD_W-1:0]     rd_old_o,
    input  wire logic [hf_pkg::REG_W-1:0] dbg_addr_i,
    output logic [hf_pkg::WORD_W-1:0]     dbg_data_o
);
    import hf_pkg::*;

    logic [WORD_W-1:0] regs_q [REG_N];

    // rollback only runs once both lanes are idle
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int r = 0; r < REG_N; r++) begin
                regs_q[r] <= '0;
            end
        end else begin
            if (wr_alu_i.valid && !wr_alu_i.exc) begin
                regs_q[wr_alu_i.rd] <= wr_alu_i.result;
            end
            if (wr_mul_i.valid && !wr_mul_i.exc) begin
                regs_q[wr_mul_i.rd] <= wr_mul_i.result;
            end
            if (rollback_i.valid) begin
                regs_q[rollback_i.rd] <= rollback_i.value;
            end
        end
    end

    assign rs1_data_o = regs_q[rs1_addr_i];
    assign rs2_data_o = regs_q[rs2_addr_i];
    assign rd_old_o   = regs_q[rd_addr_i];
    assign dbg_data_o = regs_q[dbg_addr_i];

endmodule

`default_nettype wire

/* design/hf_history_file.sv */
`timescale 1ns/1ps
`default_nettype none

module hf_history_file (
    input  wire logic                   clk_i,
    input  wire logic                   rst_i,
    input  wire hf_pkg::hf_req_t        req_i,
    input  wire hf_pkg::complete_t      complete_alu_i,
    input  wire hf_pkg::complete_t      complete_mul_i,
    input  wire logic                   exec_busy_i,
    output logic [hf_pkg::HF_PTR-1:0]   tail_id_o,
    output logic                        full_o,
    output logic                        normal_o,
    output hf_pkg::rollback_t           rollback_o,
    output logic                        exc_o,
    output logic [hf_pkg::ADDR_W-1:0]   exc_pc_o
);
    import hf_pkg::*;

    entry_status_e [HF_SIZE-1:0] status_q;
    entry_status_e [HF_SIZE-1:0] status_d;
    logic [REG_W-1:0]            dest_q [HF_SIZE];
    logic [WORD_W-1:0]           old_q  [HF_SIZE];
    logic [ADDR_W-1:0]           pc_q   [HF_SIZE];
    logic [HF_PTR-1:0]           head_q;
    logic [HF_PTR-1:0]           head_d;
    logic [HF_PTR-1:0]           tail_q;
    logic [HF_PTR-1:0]           tail_d;
    logic [HF_PTR-1:0]           last;
    hf_status_e                  state_q;
    hf_status_e                  state_d;
    logic                        empty;
    logic                        stop;
    logic                        undo_done;

    // last is the youngest occupied slot
    assign last      = tail_q - 1'b1;
    assign empty     = (head_q == tail_q);
    assign full_o    = (HF_PTR'(tail_q + 1'b1) == head_q);
    assign tail_id_o = tail_q;
    assign normal_o  = (state_q == NORMAL);
    assign undo_done = (state_q == RECOVERING) && (last == head_q);

    assign rollback_o = '{valid: (state_q == RECOVERING), rd: dest_q[last], value: old_q[last]};

    always_comb begin
        state_d = state_q;
        case (state_q)
            NORMAL: begin
                if (!empty && status_q[head_q] == EXCEPTION) begin
                    state_d = WAIT_IDLE;
                end
            end
            WAIT_IDLE: begin
                if (!exec_busy_i) begin
                    state_d = RECOVERING;
                end
            end
            RECOVERING: begin
                // the trap entry itself is the final one undone
                if (last == head_q) begin
                    state_d = NORMAL;
                end
            end
            default: state_d = NORMAL;
        endcase
    end

    always_comb begin
        status_d = status_q;
        head_d   = head_q;
        tail_d   = tail_q;
        stop     = 1'b0;
        if (state_q == RECOVERING) begin
            status_d[last] = EMPTY;
            tail_d         = last;
        end else begin
            if (complete_alu_i.valid) begin
                status_d[complete_alu_i.id] = complete_alu_i.exc ? EXCEPTION : EXEC_OK;
            end
            if (complete_mul_i.valid) begin
                status_d[complete_mul_i.id] = complete_mul_i.exc ? EXCEPTION : EXEC_OK;
            end
            if (req_i.valid) begin
                status_d[tail_q] = EXECUTING;
                tail_d           = tail_q + 1'b1;
            end
            // retire the run of finished entries at the head in one step
            if (state_q == NORMAL) begin
                for (int i = 0; i < HF_SIZE; i++) begin
                    if (!stop && head_d != tail_q && status_d[head_d] == EXEC_OK) begin
                        status_d[head_d] = EMPTY;
                        head_d           = head_d + 1'b1;
                    end else begin
                        stop = 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q  <= NORMAL;
            head_q   <= '0;
            tail_q   <= '0;
            exc_o    <= 1'b0;
            exc_pc_o <= '0;
            for (int i = 0; i < HF_SIZE; i++) begin
                status_q[i] <= EMPTY;
            end
        end else begin
            state_q  <= state_d;
            head_q   <= head_d;
            tail_q   <= tail_d;
            status_q <= status_d;
            exc_o    <= undo_done;
            if (undo_done) begin
                exc_pc_o <= pc_q[head_q];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_i.valid) begin
            dest_q[tail_q] <= req_i.rd;
            old_q[tail_q]  <= req_i.old_value;
            pc_q[tail_q]   <= req_i.pc;
        end
    end

endmodule

`default_nettype wire

/* design/hf_top.sv */
`timescale 1ns/1ps
`default_nettype none

module hf_top (
    input  wire logic                       clk_i,
    input  wire logic                       rst_i,
    input  wire logic                       instr_valid_i,
    input  wire logic [hf_pkg::INSTR_W-1:0] instr_i,
    input  wire logic [hf_pkg::ADDR_W-1:0]  pc_i,
    input  wire logic [hf_pkg::REG_W-1:0]   reg_addr_i,
    output logic                            issue_stall_o,
    output logic                            exc_o,
    output logic [hf_pkg::ADDR_W-1:0]       exc_pc_o,
    output logic [hf_pkg::WORD_W-1:0]       reg_data_o
);
    import hf_pkg::*;

    issue_t            issue;
    hf_req_t           hf_req;
    complete_t         complete_alu;
    complete_t         complete_mul;
    rollback_t         rollback;
    logic [REG_W-1:0]  rs1_addr;
    logic [REG_W-1:0]  rs2_addr;
    logic [REG_W-1:0]  rd_addr;
    logic [WORD_W-1:0] rs1_data;
    logic [WORD_W-1:0] rs2_data;
    logic [WORD_W-1:0] rd_old;
    logic [HF_PTR-1:0] tail_id;
    logic              hf_full;
    logic              hf_normal;
    logic              exec_busy;

    hf_decode i_decode (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .instr_valid_i  (instr_valid_i),
        .instr_i        (instr_i),
        .pc_i           (pc_i),
        .tail_id_i      (tail_id),
        .hf_full_i      (hf_full),
        .hf_normal_i    (hf_normal),
        .rs1_data_i     (rs1_data),
        .rs2_data_i     (rs2_data),
        .rd_old_i       (rd_old),
        .complete_alu_i (complete_alu),
        .complete_mul_i (complete_mul),
        .rs1_addr_o     (rs1_addr),
        .rs2_addr_o     (rs2_addr),
        .rd_addr_o      (rd_addr),
        .issue_o        (issue),
        .hf_req_o       (hf_req),
        .issue_stall_o  (issue_stall_o)
    );

    hf_execute i_execute (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .issue_i        (issue),
        .complete_alu_o (complete_alu),
        .complete_mul_o (complete_mul),
        .busy_o         (exec_busy)
    );

    // architectural state, written as results complete and during rollback
    hf_regfile i_regfile (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .wr_alu_i   (complete_alu),
        .wr_mul_i   (complete_mul),
        .rollback_i (rollback),
        .rs1_addr_i (rs1_addr),
        .rs1_data_o (rs1_data),
        .rs2_addr_i (rs2_addr),
        .rs2_data_o (rs2_data),
        .rd_addr_i  (rd_addr),
        .rd_old_o   (rd_old),
        .dbg_addr_i (reg_addr_i),
        .dbg_data_o (reg_data_o)
    );

    hf_history_file i_history_file (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .req_i          (hf_req),
        .complete_alu_i (complete_alu),
        .complete_mul_i (complete_mul),
        .exec_busy_i    (exec_busy),
        .tail_id_o      (tail_id),
        .full_o         (hf_full),
        .normal_o       (hf_normal),
        .rollback_o     (rollback),
        .exc_o          (exc_o),
        .exc_pc_o       (exc_pc_o)
    );

endmodule

`default_nettype wire

/* verif/hf_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module hf_tb;
    import hf_pkg::*;

    localparam int MAX_INSTR    = 64;
    localparam int MAX_TESTS    = 8;
    localparam int QUIET_CYCLES = 10;

    logic               clk_i = 1'b0;
    logic               rst_i;
    logic               instr_valid_i;
    logic [INSTR_W-1:0] instr_i;
    logic [ADDR_W-1:0]  pc_i;
    logic [REG_W-1:0]   reg_addr_i;
    logic               issue_stall_o;
    logic               exc_o;
    logic [ADDR_W-1:0]  exc_pc_o;
    logic [WORD_W-1:0]  reg_data_o;

    // instruction stream of all tests where each test owns a slice
    logic [ADDR_W-1:0]  pcs      [MAX_INSTR];
    logic [INSTR_W-1:0] words    [MAX_INSTR];
    int                 first    [MAX_TESTS];
    int                 count    [MAX_TESTS];
    logic               has_trap [MAX_TESTS];
    logic [ADDR_W-1:0]  trap_pc  [MAX_TESTS];
    logic               is_rand  [MAX_TESTS];
    logic [WORD_W-1:0]  exp_regs [MAX_TESTS*REG_N];
    logic [WORD_W-1:0]  model    [REG_N];
    int                 ntests = 0;
    int                 ninstr = 0;
    int                 errs;
    int                 passes = 0;
    int                 fails = 0;
    int                 fd;
    int                 code;
    int                 limit = 0;
    int                 cycles = 0;
    integer             seed;

    hf_top i_dut (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .pc_i          (pc_i),
        .reg_addr_i    (reg_addr_i),
        .issue_stall_o (issue_stall_o),
        .exc_o         (exc_o),
        .exc_pc_o      (exc_pc_o),
        .reg_data_o    (reg_data_o)
    );

    always #10 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("timeout: the run did not end within %0d cycles", limit);
            $display("Test failed");
            $finish;
        end
    end

    task automatic clear_test(input int t);
        first[t]    = ninstr;
        count[t]    = 0;
        has_trap[t] = 1'b0;
        trap_pc[t]  = '0;
        is_rand[t]  = 1'b0;
    endtask

    task automatic check_scan(input int got, input int want);
        if (got != want) begin
            $display("a line of verif/hf_input.txt could not be read");
            fails++;
        end
    endtask

    task automatic add_random_instrs(input int n);
        logic [31:0] r;
        opcode_e     op;
        for (int k = 0; k < n; k++) begin
            r  = $random(seed);
            op = r[0] ? LI : ADD;
            pcs[ninstr]   = ADDR_W'(8'h80 + k);
            words[ninstr] = {1'b0, op, r[7:4], r[11:8], r[15:12], r[31:16]};
            ninstr++;
            count[ntests]++;
        end
    endtask

    // line kinds are I (pc, word), X (trap pc), E (sixteen registers) and R (random count)
    task automatic load_tests();
        int          c;
        int          nrand;
        logic [31:0] pcv;
        logic [31:0] val;
        clear_test(0);
        c = $fgetc(fd);
        while (c != -1) begin
            case (c)
                "#": begin
                    while (c != "\n" && c != -1) begin
                        c = $fgetc(fd);
                    end
                end
                "I": begin
                    code = $fscanf(fd, "%h %h", pcv, val);
                    check_scan(code, 2);
                    pcs[ninstr]   = pcv[ADDR_W-1:0];
                    words[ninstr] = val;
                    ninstr++;
                    count[ntests]++;
                end
                "X": begin
                    code = $fscanf(fd, "%h", pcv);
                    check_scan(code, 1);
                    has_trap[ntests] = 1'b1;
                    trap_pc[ntests]  = pcv[ADDR_W-1:0];
                end
                "E": begin
                    for (int r = 0; r < REG_N; r++) begin
                        code = $fscanf(fd, "%h", val);
                        check_scan(code, 1);
                        exp_regs[ntests*REG_N + r] = val[WORD_W-1:0];
                    end
                    ntests++;
                    clear_test(ntests);
                end
                "R": begin
                    code = $fscanf(fd, "%d", nrand);
                    check_scan(code, 1);
                    is_rand[ntests] = 1'b1;
                    add_random_instrs(nrand);
                    ntests++;
                    clear_test(ntests);
                end
                default: ;
            endcase
            c = $fgetc(fd);
        end
    endtask

    // in-order reference model where every result keeps the low 16 bits
    task automatic exec_model(input int from, input int num);
        logic [INSTR_W-1:0] w;
        logic [REG_W-1:0]   rd;
        logic [REG_W-1:0]   ra;
        logic [REG_W-1:0]   rb;
        for (int k = 0; k < num; k++) begin
            w  = words[from + k];
            rd = w[27:24];
            ra = w[23:20];
            rb = w[19:16];
            case (w[30:28])
                ADD:     model[rd] = model[ra] + model[rb];
                SUB:     model[rd] = model[ra] - model[rb];
                XOR:     model[rd] = model[ra] ^ model[rb];
                LI:      model[rd] = w[15:0];
                MUL:     model[rd] = model[ra] * model[rb];
                default: ;
            endcase
        end
    endtask

    task automatic predict_regs(input int t);
        exec_model(first[t], count[t]);
        for (int r = 0; r < REG_N; r++) begin
            exp_regs[t*REG_N + r] = model[r];
        end
    endtask

    // reads every register through the debug port and compares it with the model
    task automatic check_regs();
        for (int r = 0; r < REG_N; r++) begin
            reg_addr_i = REG_W'(r);
            @(negedge clk_i);
            assert (reg_data_o == model[r]) else begin
                $display("FAILED reg_data_o r%0d: expected %h, got %h",
                         r, model[r], reg_data_o);
                errs++;
            end
            @(posedge clk_i);
            #2;
        end
    endtask

    task automatic run_test(input int t);
        int   idx;
        int   quiet;
        int   n;
        int   base;
        int   excs;
        int   j;
        int   tpos;
        logic acc;
        logic stalled;
        errs  = 0;
        idx   = 0;
        quiet = 0;
        excs  = 0;
        n     = count[t];
        base  = first[t];
        if (is_rand[t]) begin
            predict_regs(t);
        end
        if (t == 0) begin
            @(negedge clk_i);
            assert (!issue_stall_o) else begin
                $display("FAILED issue_stall_o: expected %h, got %h", 1'b0, issue_stall_o);
                errs++;
            end
            assert (!exc_o) else begin
                $display("FAILED exc_o: expected %h, got %h", 1'b0, exc_o);
                errs++;
            end
            @(posedge clk_i);
            #2;
        end
        while (idx < n || quiet < QUIET_CYCLES) begin
            instr_valid_i = (idx < n);
            if (idx < n) begin
                instr_i = words[base + idx];
                pc_i    = pcs[base + idx];
            end
            @(negedge clk_i);
            acc     = instr_valid_i && !issue_stall_o;
            stalled = issue_stall_o;
            @(posedge clk_i);
            #2;
            if (exc_o) begin
                excs++;
                quiet = 0;
                assert (has_trap[t] && excs == 1) else begin
                    $display("test %0d: exception pulse that was not expected, pc %h",
                             t + 1, exc_pc_o);
                    errs++;
                end
                if (has_trap[t]) begin
                    assert (exc_pc_o == trap_pc[t]) else begin
                        $display("FAILED exc_pc_o: expected %h, got %h", trap_pc[t], exc_pc_o);
                        errs++;
                    end
                end
                // the handler returns to the instruction after the trap
                idx = n;
                for (j = 0; j < n; j++) begin
                    if (pcs[base + j] == exc_pc_o) begin
                        idx = j + 1;
                    end
                end
                // after rollback the registers hold the in-order state before the trap
                if (has_trap[t] && excs == 1) begin
                    tpos = 0;
                    for (j = 0; j < n; j++) begin
                        if (pcs[base + j] == trap_pc[t]) begin
                            tpos = j;
                        end
                    end
                    instr_valid_i = 1'b0;
                    exec_model(base, tpos);
                    check_regs();
                end
            end else begin
                if (acc) begin
                    idx++;
                end
                quiet = (idx >= n && !stalled) ? quiet + 1 : 0;
            end
        end
        if (has_trap[t]) begin
            assert (excs != 0) else begin
                $display("test %0d: no exception pulse came for the trap at pc %h",
                         t + 1, trap_pc[t]);
                errs++;
            end
        end
        // the expected state also seeds the model for later random tests
        for (int r = 0; r < REG_N; r++) begin
            model[r] = exp_regs[t*REG_N + r];
        end
        check_regs();
        if (errs == 0) begin
            passes++;
            $display("test %0d passed", t + 1);
        end else begin
            fails++;
            $display("test %0d had %0d errors", t + 1, errs);
        end
    endtask

    initial begin
        rst_i         = 1'b1;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        pc_i          = '0;
        reg_addr_i    = '0;
        seed          = 32'h76e9;
        for (int r = 0; r < REG_N; r++) begin
            model[r] = '0;
        end
        fd = $fopen("verif/hf_input.txt", "r");
        if (fd == 0) begin
            $display("cannot open verif/hf_input.txt");
            fails++;
        end else begin
            load_tests();
            $fclose(fd);
        end
        // a stalled instruction waits for at most a multiply and a rollback
        limit = 40 * ninstr + 200;
        repeat (16) @(posedge clk_i);
        #2;
        rst_i = 1'b0;
        for (int t = 0; t < ntests; t++) begin
            run_test(t);
        end
        $display("summary: %0d tests passed, %0d tests with errors", passes, fails);
        if (fails == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
design/hf_pkg.sv
design/hf_decode.sv
design/hf_execute.sv
design/hf_regfile.sv
design/hf_history_file.sv
design/hf_top.sv
verif/hf_tb.sv

/* verif/hf_input.txt */
# I pc word = instruction in hex, X pc = expected trap pc, E = expected r0..r15 in hex
# R n = n seeded random LI/ADD instructions; each E or R line closes a test
E 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
I 10 41001234
I 11 42000F0F
I 12 13120000
I 13 24310000
I 14 35410000
I 15 26230000
I 16 11160000
E 0000 0000 0F0F 2143 0F0F 1D3B EDCC 0000 0000 0000 0000 0000 0000 0000 0000 0000
I 20 47000123
I 21 48000045
I 22 59780000
I 23 4A0000AA
I 24 1B250000
I 25 3CB90000
E 0000 0000 0F0F 2143 0F0F 1D3B EDCC 0123 0045 4E6F 00AA 2C4A 6225 0000 0000 0000
I 30 5D780000
I 31 5E2A0000
I 32 4F00BEEF
I 33 518A0000
I 34 43000001
I 35 54220000
I 36 45007777
I 37 56770000
I 38 59A80000
E 0000 2DD2 0F0F 0001 C2E1 7777 4AC9 0123 0045 2DD2 00AA 2C4A 6225 4E6F FFF6 BEEF
I 50 41000003
I 51 42000004
I 52 13120000
I 53 60000000
I 54 11110000
I 55 45000055
I 56 36120000
X 53
E 0000 0006 0004 0007 C2E1 0055 0002 0123 0045 2DD2 00AA 2C4A 6225 4E6F FFF6 BEEF
R 20
